// ==== Makefile ====
SRCS := $(shell cat sim.f)

.PHONY: all run clean

all: obj_dir/Vtb_ctrl_periph

obj_dir/Vtb_ctrl_periph: sim.f $(SRCS)
	verilator --binary --timing --assert -f sim.f \
		--top-module tb_ctrl_periph -o Vtb_ctrl_periph

run: obj_dir/Vtb_ctrl_periph
	./obj_dir/Vtb_ctrl_periph

clean:
	rm -rf obj_dir

// ==== dv/ctrl_periph_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module ctrl_periph_props (
	input wire                          clk,
	input wire                          resetn,
	input wire ctrl_pkg::apb_req_t      apb_req,
	input wire ctrl_pkg::apb_rsp_t      apb_rsp,
	input wire serial_pkg::flash_pins_t flash_pins,
	input wire                          ovr_enable,
	input wire                          uart_tx,
	input wire                          bus_error
);

	logic uart_write;
	logic tx_used;

	assign uart_write = apb_req.psel && apb_req.penable && apb_req.pwrite &&
		apb_req.paddr == ctrl_pkg::ADDR_UART;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			tx_used <= 1'b0;
		end else if (uart_write) begin
			tx_used <= 1'b1;
		end
	end

	// An error response also sets the sticky error flag
	assert property (@(posedge clk) disable iff (!resetn)
		apb_rsp.pslverr |-> apb_rsp.pready ##1 bus_error)
		else $error("pslverr without pready, or bus_error not set after it");

	// Sequencer is still idle in the cycle after a release
	assert property (@(posedge clk) disable iff (!resetn)
		(ovr_enable || $past(ovr_enable)) |-> flash_pins.csb)
		else $error("flash csb low while override is enabled or just released");

	// Line idles high until software sends something
	assert property (@(posedge clk) disable iff (!resetn)
		!(tx_used || uart_write) |-> uart_tx)
		else $error("uart_tx left idle before any UART write");

endmodule

bind ctrl_periph_top ctrl_periph_props u_ctrl_periph_props (
	.clk        (clk),
	.resetn     (resetn),
	.apb_req    (apb_req),
	.apb_rsp    (apb_rsp),
	.flash_pins (flash_pins),
	.ovr_enable (flash_ovr.enable),
	.uart_tx    (uart_tx),
	.bus_error  (bus_error)
);

`default_nettype wire

// ==== dv/tb_ctrl_periph.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_ctrl_periph;

	localparam int BIT = serial_pkg::UART_BIT_CYCLES;
	localparam longint WATCHDOG_CYCLES = 200 * 10 * BIT;

	logic                           clk;
	logic                           resetn;
	ctrl_pkg::apb_req_t             apb_req;
	ctrl_pkg::apb_rsp_t             apb_rsp;
	logic                           uart_rx;
	logic                           uart_tx;
	serial_pkg::flash_pins_t        flash_pins;
	logic [3:0]                     flash_io_di;
	logic                           accel_csb;
	logic                           accel_clk;
	logic [ctrl_pkg::LED_COUNT-1:0] leds;
	logic                           bus_error;

	integer     seed;
	logic [7:0] tx_seen[$];
	logic       use_test_di;
	logic [3:0] test_di;
	logic [3:0] model_di;
	logic [23:0] fm_addr;
	int         fm_count;

	ctrl_periph_top u_ctrl_periph_top (
		.clk         (clk),
		.resetn      (resetn),
		.apb_req     (apb_req),
		.apb_rsp     (apb_rsp),
		.uart_rx     (uart_rx),
		.uart_tx     (uart_tx),
		.flash_pins  (flash_pins),
		.flash_io_di (flash_io_di),
		.accel_csb   (accel_csb),
		.accel_clk   (accel_clk),
		.leds        (leds),
		.bus_error   (bus_error)
	);

	assign flash_io_di = use_test_di ? test_di : model_di;

	always #50 clk = ~clk;

	task automatic expect_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
		assert (got === exp) else begin
			$display("[ERROR] %0t ns: %s got %h expected %h", $time, what, got, exp);
			$display("Simulation FAILED");
			$fatal(1, "mismatch");
		end
	endtask

	// Flash content rule
	function automatic logic [7:0] flash_byte(input logic [23:0] a);
		return a[7:0] ^ 8'h5A;
	endfunction

	function automatic logic [31:0] flash_word(input logic [23:0] a);
		return {flash_byte(a + 24'd3), flash_byte(a + 24'd2), flash_byte(a + 24'd1),
			flash_byte(a)};
	endfunction

	task automatic apb_transfer(input logic wr, input logic [31:0] addr,
		input logic [31:0] wdata, input logic [3:0] strb,
		output logic [31:0] rdata, output logic err);
		@(negedge clk);
		apb_req.psel    = 1'b1;
		apb_req.penable = 1'b0;
		apb_req.pwrite  = wr;
		apb_req.paddr   = addr;
		apb_req.pwdata  = wdata;
		apb_req.pstrb   = strb;
		@(negedge clk);
		apb_req.penable = 1'b1;
		#10;
		while (!apb_rsp.pready) begin
			@(negedge clk);
			#10;
		end
		rdata = apb_rsp.prdata;
		err   = apb_rsp.pslverr;
		@(negedge clk);
		apb_req = '0;
	endtask

	task automatic apb_write(input logic [31:0] addr, input logic [31:0] data,
		output logic err);
		logic [31:0] unused;
		apb_transfer(1'b1, addr, data, 4'hf, unused, err);
	endtask

	task automatic apb_read(input logic [31:0] addr, output logic [31:0] data,
		output logic err);
		apb_transfer(1'b0, addr, 32'h0, 4'h0, data, err);
	endtask

	task automatic uart_send(input logic [7:0] b);
		logic [9:0] frame;
		frame = {1'b1, b, 1'b0};
		for (int i = 0; i < 10; i++) begin
			@(negedge clk);
			uart_rx = frame[i];
			repeat (BIT - 1) @(negedge clk);
		end
	endtask

	task automatic test_leds();
		logic [31:0] r;
		logic [31:0] d;
		logic        err;
		for (int i = 0; i < 4; i++) begin
			r = $random(seed);
			apb_write(ctrl_pkg::ADDR_LED, r, err);
			apb_read(ctrl_pkg::ADDR_LED, d, err);
			expect_eq(d, {27'h0, r[4:0]}, "LED read-back");
			expect_eq({27'h0, leds}, {27'h0, r[4:0]}, "leds port");
		end
	endtask

	task automatic test_override();
		logic [31:0] r;
		logic [31:0] d;
		logic        err;
		r = $random(seed);
		@(negedge clk);
		use_test_di = 1'b1;
		test_di     = r[23:20];
		apb_write(ctrl_pkg::ADDR_FLASH_CTRL,
			{1'b1, 7'h0, 6'h0, r[17:16], 4'h0, r[11:8], 4'h0, r[3:0]}, err);
		apb_read(ctrl_pkg::ADDR_FLASH_CTRL, d, err);
		expect_eq(d, {1'b1, 7'h0, 6'h0, r[17:16], 4'h0, r[11:8], 4'h0, r[23:20]},
			"override read-back");
		expect_eq({28'h0, flash_pins.oe}, {28'h0, r[11:8]}, "override oe");
		expect_eq({28'h0, flash_pins.dout}, {28'h0, r[3:0]}, "override dout");
		expect_eq({30'h0, flash_pins.clk, flash_pins.csb}, 32'h3, "flash clk and csb");
		expect_eq({30'h0, accel_csb, accel_clk}, {30'h0, r[17:16]}, "accel pins");
		apb_write(ctrl_pkg::ADDR_FLASH_CTRL, 32'h0000_0000, err);
		// accel_csb idles high, accel_clk still follows the register
		expect_eq({30'h0, accel_csb, accel_clk}, 32'h2, "accel pins after release");
		@(negedge clk);
		use_test_di = 1'b0;
	endtask

	task automatic test_uart_tx();
		logic [31:0] r;
		logic [7:0]  sent[$];
		logic        err;
		for (int i = 0; i < 3; i++) begin
			r = $random(seed);
			sent.push_back(r[7:0]);
			apb_write(ctrl_pkg::ADDR_UART, r, err);
		end
		while (tx_seen.size() < 3) begin
			@(posedge clk);
		end
		for (int i = 0; i < 3; i++) begin
			expect_eq({24'h0, tx_seen[i]}, {24'h0, sent[i]}, "UART transmit byte");
		end
	endtask

	task automatic test_uart_rx();
		logic [31:0] r;
		logic [31:0] d;
		logic [7:0]  sent[3];
		logic        err;
		for (int i = 0; i < 3; i++) begin
			r = $random(seed);
			sent[i] = r[7:0];
			uart_send(sent[i]);
		end
		repeat (2 * BIT) @(negedge clk);
		for (int i = 0; i < 3; i++) begin
			apb_read(ctrl_pkg::ADDR_UART, d, err);
			expect_eq(d, {24'h0, sent[i]}, "UART receive byte");
		end
		apb_read(ctrl_pkg::ADDR_UART, d, err);
		expect_eq(d, 32'hffff_ffff, "UART read of empty buffer");
	endtask

	task automatic test_flash();
		logic [31:0] r;
		logic [31:0] d;
		logic [23:0] a;
		logic        err;
		r = $random(seed);
		a = {r[23:2], 2'b00};
		apb_read(ctrl_pkg::FLASH_WINDOW_BASE | {8'h0, a}, d, err);
		expect_eq(d, flash_word(a), "flash first read");
		expect_eq({8'h0, fm_addr}, {8'h0, a}, "flash command address");
		apb_read(ctrl_pkg::FLASH_WINDOW_BASE | {8'h0, a + 24'd4}, d, err);
		expect_eq(d, flash_word(a + 24'd4), "flash sequential read");
		// Streaming sends no new command
		expect_eq({8'h0, fm_addr}, {8'h0, a}, "flash address after sequential read");
		a = a ^ 24'h00_1100;
		apb_read(ctrl_pkg::FLASH_WINDOW_BASE | {8'h0, a}, d, err);
		expect_eq(d, flash_word(a), "flash read after jump");
		expect_eq({8'h0, fm_addr}, {8'h0, a}, "flash address after jump");
		expect_eq({31'h0, err}, 32'h0, "flash read pslverr");
	endtask

	task automatic test_errors();
		logic [31:0] d;
		logic        err;
		expect_eq({31'h0, bus_error}, 32'h0, "bus_error before faults");
		apb_read(32'h0000_0010, d, err);
		expect_eq({31'h0, err}, 32'h1, "pslverr on unmapped read");
		apb_write(ctrl_pkg::FLASH_WINDOW_BASE, 32'h1234_5678, err);
		expect_eq({31'h0, err}, 32'h1, "pslverr on flash window write");
		repeat (10) @(negedge clk);
		expect_eq({31'h0, bus_error}, 32'h1, "sticky bus_error");
	endtask

	// Deserializer on the transmit line
	initial begin
		logic [7:0] b;
		wait (resetn);
		forever begin
			@(negedge uart_tx);
			repeat (BIT / 2) @(posedge clk);
			expect_eq({31'h0, uart_tx}, 32'h0, "UART start bit");
			for (int i = 0; i < 8; i++) begin
				repeat (BIT) @(posedge clk);
				b[i] = uart_tx;
			end
			repeat (BIT) @(posedge clk);
			expect_eq({31'h0, uart_tx}, 32'h1, "UART stop bit");
			tx_seen.push_back(b);
		end
	end

	// Flash model, command nibbles on rising clk
	always @(posedge flash_pins.clk) begin
		if (flash_pins.csb === 1'b0) begin
			if (fm_count < 6) begin
				fm_addr = {fm_addr[19:0], flash_pins.dout};
			end
			fm_count++;
		end
	end

	always @(posedge flash_pins.csb) begin
		fm_count = 0;
	end

	always @(negedge flash_pins.clk) begin
		logic [7:0] b;
		int         idx;
		if (flash_pins.csb === 1'b0 && fm_count >= 8) begin
			idx = fm_count - 8;
			b   = flash_byte(fm_addr + 24'(idx / 2));
			model_di <= idx[0] ? b[3:0] : b[7:4];
		end
	end

	initial begin
		#(WATCHDOG_CYCLES * 100);
		$display("Timeout: the tests did not finish within the watchdog time");
		$display("Simulation FAILED");
		$fatal(1, "watchdog expired");
	end

	initial begin
		seed        = 32'h2d169545;
		clk         = 1'b0;
		resetn      = 1'b0;
		apb_req     = '0;
		uart_rx     = 1'b1;
		use_test_di = 1'b0;
		test_di     = 4'h0;
		model_di    = 4'h0;
		fm_addr     = '0;
		fm_count    = 0;
		repeat (16) @(negedge clk);
		resetn = 1'b1;
		test_leds();
		test_override();
		test_uart_tx();
		test_uart_rx();
		test_flash();
		test_errors();
		$display("Simulation PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim.f ====
source/ctrl_pkg.sv
source/serial_pkg.sv
source/ctrl_apb_regs.sv
source/ctrl_uart_rx.sv
source/ctrl_uart_tx.sv
source/ctrl_flash_reader.sv
source/ctrl_periph_top.sv
dv/tb_ctrl_periph.sv
dv/ctrl_periph_props.sv

// ==== source/ctrl_apb_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module ctrl_apb_regs (
	input  wire                                    clk,
	input  wire                                    resetn,
	input  wire  ctrl_pkg::apb_req_t               apb_req,
	output ctrl_pkg::apb_rsp_t                     apb_rsp,
	output logic [ctrl_pkg::LED_COUNT-1:0]         leds,
	output logic                                   bus_error,
	output ctrl_pkg::flash_ovr_t                   flash_ovr,
	input  wire  [3:0]                             flash_io_di,
	output logic                                   tx_start,
	output logic [7:0]                             tx_byte,
	input  wire                                    tx_done,
	output logic                                   rx_pop,
	input  wire                                    rx_ack,
	input  wire  [31:0]                            rx_word,
	output logic                                   flash_valid,
	output logic [serial_pkg::FLASH_ADDR_BITS-1:0] flash_addr,
	input  wire                                    flash_ready,
	input  wire  [31:0]                            flash_rdata
);

	logic        access;
	logic        sel_led;
	logic        sel_uart;
	logic        sel_fctl;
	logic        sel_win;
	logic        slv_err;
	logic [31:0] ovr_rdata;

	assign access   = apb_req.psel && apb_req.penable;
	assign sel_led  = apb_req.paddr == ctrl_pkg::ADDR_LED;
	assign sel_uart = apb_req.paddr == ctrl_pkg::ADDR_UART;
	assign sel_fctl = apb_req.paddr == ctrl_pkg::ADDR_FLASH_CTRL;
	assign sel_win  = apb_req.paddr[31:24] == ctrl_pkg::FLASH_WINDOW_BASE[31:24];

	// Unmapped space, or a write into the read-only window
	assign slv_err = !(sel_led || sel_uart || sel_fctl || sel_win) ||
		(sel_win && apb_req.pwrite);

	assign tx_start    = access && sel_uart && apb_req.pwrite;
	assign tx_byte     = apb_req.pwdata[7:0];
	assign rx_pop      = access && sel_uart && !apb_req.pwrite;
	assign flash_valid = access && sel_win && !apb_req.pwrite;
	assign flash_addr  = apb_req.paddr[serial_pkg::FLASH_ADDR_BITS-1:0];

	// Data lines are read back live
	assign ovr_rdata = {
		flash_ovr.enable, 7'h00,
		6'h00, flash_ovr.accel_csb, flash_ovr.accel_clk,
		4'h0, flash_ovr.oe,
		4'h0, flash_io_di
	};

	always_comb begin
		apb_rsp = '0;
		if (access) begin
			if (slv_err) begin
				apb_rsp.pready  = 1'b1;
				apb_rsp.pslverr = 1'b1;
			end else if (sel_led) begin
				apb_rsp.pready = 1'b1;
				apb_rsp.prdata[ctrl_pkg::LED_COUNT-1:0] = leds;
			end else if (sel_fctl) begin
				apb_rsp.pready = 1'b1;
				apb_rsp.prdata = ovr_rdata;
			end else if (sel_uart) begin
				// Writes wait for the stop bit, reads for the pop
				apb_rsp.pready = apb_req.pwrite ? tx_done : rx_ack;
				apb_rsp.prdata = rx_word;
			end else begin
				apb_rsp.pready = flash_ready;
				apb_rsp.prdata = flash_rdata;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			leds      <= '0;
			bus_error <= 1'b0;
			flash_ovr <= '{enable: 1'b0, oe: 4'h0, dout: 4'h0, accel_csb: 1'b1, accel_clk: 1'b1};
		end else if (access) begin
			// Sticky until reset
			if (slv_err) begin
				bus_error <= 1'b1;
			end
			if (apb_req.pwrite && sel_led && apb_req.pstrb[0]) begin
				leds <= apb_req.pwdata[ctrl_pkg::LED_COUNT-1:0];
			end
			if (apb_req.pwrite && sel_fctl) begin
				if (apb_req.pstrb[3]) begin
					flash_ovr.enable <= apb_req.pwdata[31];
				end
				if (apb_req.pstrb[2]) begin
					flash_ovr.accel_csb <= apb_req.pwdata[17];
					flash_ovr.accel_clk <= apb_req.pwdata[16];
				end
				if (apb_req.pstrb[1]) begin
					flash_ovr.oe <= apb_req.pwdata[11:8];
				end
				if (apb_req.pstrb[0]) begin
					flash_ovr.dout <= apb_req.pwdata[3:0];
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/ctrl_flash_reader.sv ====
`timescale 1ns/1ps
`default_nettype none

module ctrl_flash_reader (
	input  wire                                    clk,
	input  wire                                    resetn,
	input  wire                                    flash_valid,
	input  wire  [serial_pkg::FLASH_ADDR_BITS-1:0] flash_addr,
	output logic                                   flash_ready,
	output logic [31:0]                            flash_rdata,
	input  wire  ctrl_pkg::flash_ovr_t             flash_ovr,
	input  wire  [3:0]                             flash_io_di,
	output serial_pkg::flash_pins_t                flash_pins,
	output logic                                   accel_csb,
	output logic                                   accel_clk
);

	typedef logic [serial_pkg::FLASH_ADDR_BITS-1:0] faddr_t;

	logic [4:0]                             state;
	faddr_t                                 next_addr;
	logic [serial_pkg::FLASH_ADDR_BITS+3:0] cmd_shift;
	logic                                   req;
	logic                                   seq_clk;
	logic                                   seq_csb;
	logic [3:0]                             seq_oe;
	logic [3:0]                             seq_dout;

	// The completing cycle is not a new request
	assign req = flash_valid && !flash_ready;

	// Even states drop clk, odd states raise it
	always_ff @(posedge clk) begin
		flash_ready <= 1'b0;
		if (!resetn || flash_ovr.enable) begin
			state    <= 5'd0;
			seq_clk  <= 1'b0;
			seq_csb  <= 1'b1;
			seq_oe   <= 4'h0;
			seq_dout <= 4'h0;
		end else begin
			if (state == 5'd0) begin
				next_addr <= flash_addr;
				seq_clk   <= 1'b0;
				if (req && seq_csb) begin
					seq_csb   <= 1'b0;
					seq_oe    <= 4'hf;
					seq_dout  <= flash_addr[serial_pkg::FLASH_ADDR_BITS-1 -: 4];
					cmd_shift <= {flash_addr[serial_pkg::FLASH_ADDR_BITS-5:0],
						serial_pkg::FLASH_MODE_HI, serial_pkg::FLASH_MODE_LO};
					state     <= 5'd1;
				end else begin
					seq_csb  <= 1'b1;
					seq_oe   <= 4'h0;
					seq_dout <= 4'h0;
				end
			end else if (!state[0]) begin
				seq_clk <= 1'b0;
				// Rest of the address, then the mode nibbles
				if (state < 5'd16) begin
					seq_dout  <= cmd_shift[serial_pkg::FLASH_ADDR_BITS+3 -: 4];
					cmd_shift <= cmd_shift << 4;
				end
				state <= state + 1'b1;
			end else begin
				seq_clk <= 1'b1;
				if (state == 5'd15) begin
					seq_oe <= 4'h0;
				end
				// High nibble first, bytes little-endian
				if (state >= 5'd17) begin
					flash_rdata[{state[3:2], ~state[1], 2'b00} +: 4] <= flash_io_di;
				end
				if (state != 5'd31) begin
					state <= state + 1'b1;
				end else if (req && flash_addr == next_addr) begin
					next_addr   <= next_addr + faddr_t'(4);
					flash_ready <= 1'b1;
					state       <= 5'd16;
				end
			end
			// Any other address ends the stream
			if (req && state != 5'd0 && flash_addr != next_addr) begin
				state <= 5'd0;
			end
		end
	end

	always_comb begin
		flash_pins.clk  = flash_ovr.enable ? 1'b1 : seq_clk;
		flash_pins.csb  = flash_ovr.enable ? 1'b1 : seq_csb;
		flash_pins.oe   = flash_ovr.enable ? flash_ovr.oe : seq_oe;
		flash_pins.dout = flash_ovr.enable ? flash_ovr.dout : seq_dout;
	end

	assign accel_csb = flash_ovr.enable ? flash_ovr.accel_csb : 1'b1;
	assign accel_clk = flash_ovr.accel_clk;

endmodule

`default_nettype wire

// ==== source/ctrl_periph_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module ctrl_periph_top (
	input  wire                            clk,
	input  wire                            resetn,
	input  wire  ctrl_pkg::apb_req_t       apb_req,
	output ctrl_pkg::apb_rsp_t             apb_rsp,
	input  wire                            uart_rx,
	output logic                           uart_tx,
	output serial_pkg::flash_pins_t        flash_pins,
	input  wire  [3:0]                     flash_io_di,
	output logic                           accel_csb,
	output logic                           accel_clk,
	output logic [ctrl_pkg::LED_COUNT-1:0] leds,
	output logic                           bus_error
);

	logic                                   tx_start;
	logic [7:0]                             tx_byte;
	logic                                   tx_done;
	logic                                   rx_pop;
	logic                                   rx_ack;
	logic [31:0]                            rx_word;
	logic                                   flash_valid;
	logic [serial_pkg::FLASH_ADDR_BITS-1:0] flash_addr;
	logic                                   flash_ready;
	logic [31:0]                            flash_rdata;
	ctrl_pkg::flash_ovr_t                   flash_ovr;

	ctrl_apb_regs u_ctrl_apb_regs (
		.clk         (clk),
		.resetn      (resetn),
		.apb_req     (apb_req),
		.apb_rsp     (apb_rsp),
		.leds        (leds),
		.bus_error   (bus_error),
		.flash_ovr   (flash_ovr),
		.flash_io_di (flash_io_di),
		.tx_start    (tx_start),
		.tx_byte     (tx_byte),
		.tx_done     (tx_done),
		.rx_pop      (rx_pop),
		.rx_ack      (rx_ack),
		.rx_word     (rx_word),
		.flash_valid (flash_valid),
		.flash_addr  (flash_addr),
		.flash_ready (flash_ready),
		.flash_rdata (flash_rdata)
	);

	ctrl_uart_rx u_ctrl_uart_rx (
		.clk     (clk),
		.resetn  (resetn),
		.uart_rx (uart_rx),
		.rx_pop  (rx_pop),
		.rx_ack  (rx_ack),
		.rx_word (rx_word)
	);

	ctrl_uart_tx u_ctrl_uart_tx (
		.clk      (clk),
		.resetn   (resetn),
		.tx_start (tx_start),
		.tx_byte  (tx_byte),
		.tx_done  (tx_done),
		.uart_tx  (uart_tx)
	);

	ctrl_flash_reader u_ctrl_flash_reader (
		.clk         (clk),
		.resetn      (resetn),
		.flash_valid (flash_valid),
		.flash_addr  (flash_addr),
		.flash_ready (flash_ready),
		.flash_rdata (flash_rdata),
		.flash_ovr   (flash_ovr),
		.flash_io_di (flash_io_di),
		.flash_pins  (flash_pins),
		.accel_csb   (accel_csb),
		.accel_clk   (accel_clk)
	);

endmodule

`default_nettype wire

// ==== source/ctrl_pkg.sv ====
`default_nettype none

package ctrl_pkg;

	typedef struct packed {
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [31:0] paddr;
		logic [31:0] pwdata;
		logic [3:0]  pstrb;
	} apb_req_t;

	typedef struct packed {
		logic [31:0] prdata;
		logic        pready;
		logic        pslverr;
	} apb_rsp_t;

	// Software control of the flash and accelerator pins
	typedef struct packed {
		logic       enable;
		logic [3:0] oe;
		logic [3:0] dout;
		logic       accel_csb;
		logic       accel_clk;
	} flash_ovr_t;

	// Register map
	localparam logic [31:0] ADDR_LED        = 32'h0000_0000;
	localparam logic [31:0] ADDR_UART       = 32'h0000_0004;
	localparam logic [31:0] ADDR_FLASH_CTRL = 32'h0000_0008;

	// Top byte selects the window, the rest is the flash byte address
	localparam logic [31:0] FLASH_WINDOW_BASE = 32'h0100_0000;

	localparam int LED_COUNT = 5;

endpackage

`default_nettype wire

// ==== source/ctrl_uart_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module ctrl_uart_rx (
	input  wire         clk,
	input  wire         resetn,
	input  wire         uart_rx,
	input  wire         rx_pop,
	output logic        rx_ack,
	output logic [31:0] rx_word
);

	typedef logic [$clog2(serial_pkg::UART_BIT_CYCLES)-1:0] div_t;

	logic        rx_meta;
	logic        rx_sync;
	logic        rx_prev;
	div_t        wait_cnt;
	logic [3:0]  rx_state;
	logic [7:0]  rx_shift;
	logic        byte_valid;
	logic [31:0] rbuf;
	logic [3:0]  rbuf_valid;
	logic [1:0]  fill_slot;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_meta <= uart_rx;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	// 1 samples the start bit, 2 to 9 the data bits, 10 waits for mid stop
	always_ff @(posedge clk) begin
		byte_valid <= 1'b0;
		if (!resetn) begin
			rx_state <= 4'd0;
			wait_cnt <= '0;
		end else if (rx_state == 4'd0) begin
			if (rx_prev && !rx_sync) begin
				wait_cnt <= div_t'(serial_pkg::UART_BIT_CYCLES / 2);
				rx_state <= 4'd1;
			end
		end else if (wait_cnt != '0) begin
			wait_cnt <= wait_cnt - 1'b1;
		end else if (rx_state == 4'd10) begin
			byte_valid <= 1'b1;
			rx_state   <= 4'd0;
		end else begin
			wait_cnt <= div_t'(serial_pkg::UART_BIT_CYCLES - 1);
			rx_shift <= {rx_sync, rx_shift[7:1]};
			rx_state <= rx_state + 1'b1;
		end
	end

	// Buffer fills from the low byte up
	always_comb begin
		case (rbuf_valid)
			4'b0000: fill_slot = 2'd0;
			4'b0001: fill_slot = 2'd1;
			4'b0011: fill_slot = 2'd2;
			default: fill_slot = 2'd3;
		endcase
	end

	// A pop waits one cycle behind an arriving byte
	assign rx_ack  = rx_pop && !byte_valid;
	assign rx_word = rbuf_valid[0] ? {24'h00_0000, rbuf[7:0]} : '1;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			rbuf_valid <= 4'b0000;
		end else if (byte_valid) begin
			rbuf_valid <= {rbuf_valid[2:0], 1'b1};
		end else if (rx_ack) begin
			rbuf_valid <= {1'b0, rbuf_valid[3:1]};
		end
	end

	always_ff @(posedge clk) begin
		if (byte_valid && !rbuf_valid[3]) begin
			rbuf[{fill_slot, 3'b000} +: 8] <= rx_shift;
		end else if (!byte_valid && rx_ack) begin
			rbuf <= {8'h00, rbuf[31:8]};
		end
	end

endmodule

`default_nettype wire

// ==== source/ctrl_uart_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

module ctrl_uart_tx (
	input  wire        clk,
	input  wire        resetn,
	input  wire        tx_start,
	input  wire  [7:0] tx_byte,
	output logic       tx_done,
	output logic       uart_tx
);

	typedef logic [$clog2(serial_pkg::UART_BIT_CYCLES)-1:0] div_t;

	div_t       div_cnt;
	logic       tick;
	logic [8:0] shift_q;
	logic [3:0] bit_cnt;

	assign tick    = div_cnt == div_t'(serial_pkg::UART_BIT_CYCLES - 1);
	assign uart_tx = shift_q[0];

	// Stop bit has been on the line for a full bit time
	assign tx_done = tx_start && tick && bit_cnt == 4'd1;

	// Free running, so the first bit starts on the next tick
	always_ff @(posedge clk) begin
		if (!resetn || tick) begin
			div_cnt <= '0;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			shift_q <= '1;
			bit_cnt <= 4'd0;
		end else if (tx_start && tick) begin
			if (bit_cnt == 4'd0) begin
				shift_q <= {tx_byte, 1'b0};
				bit_cnt <= 4'd10;
			end else begin
				shift_q <= {1'b1, shift_q[8:1]};
				bit_cnt <= bit_cnt - 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/serial_pkg.sv ====
`default_nettype none

package serial_pkg;

	// Flash outputs, the pads sit outside the design
	typedef struct packed {
		logic       clk;
		logic       csb;
		logic [3:0] oe;
		logic [3:0] dout;
	} flash_pins_t;

	// Mode nibbles sent after the address of a quad read
	localparam logic [3:0] FLASH_MODE_HI = 4'hA;
	localparam logic [3:0] FLASH_MODE_LO = 4'h5;

	localparam int FLASH_ADDR_BITS = 24;

	// Clock cycles per UART bit
	localparam int UART_BIT_CYCLES = 104;

endpackage

`default_nettype wire
